// ==== sim.f ====
+incdir+verilog
verilog/bridge_pkg.sv
verilog/fifo_bp.sv
verilog/host_regs.sv
verilog/axi_master_port.sv
verilog/kernel.sv
test/kernel_asserts.sv
test/tb_kernel.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the kernel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f sim.f --top-module tb_kernel -o vsim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/vsim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

// ==== test/tb_kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module tb_kernel;

  localparam int TIMEOUT = 200; // cycles per wait loop

  logic                   clk;
  logic                   rstn;
  logic                   ocu_rstn;
  logic                   host_en;
  logic [3:0]             host_we;
  bridge_pkg::host_addr_t host_addr;
  bridge_pkg::host_word_t host_din;
  bridge_pkg::host_word_t host_dout;
  bridge_pkg::axi_addr_t  awaddr;
  logic                   awvalid;
  logic                   awready;
  bridge_pkg::axi_data_t  wdata;
  bridge_pkg::axi_strb_t  wstrb;
  logic                   wvalid;
  logic                   wready;
  bridge_pkg::axi_resp_t  bresp;
  logic                   bvalid;
  logic                   bready;
  bridge_pkg::axi_addr_t  araddr;
  logic                   arvalid;
  logic                   arready;
  bridge_pkg::axi_data_t  rdata;
  bridge_pkg::axi_resp_t  rresp;
  logic                   rvalid;
  logic                   rready;

  integer seed = 88568;

  bridge_pkg::host_word_t                  stage_model [8]; // last words the host wrote
  bridge_pkg::axi_addr_t                   exp_aw [$];
  logic [`BR_STRB_W+`BR_DATA_W-1:0]        exp_w [$];       // strb, data
  bridge_pkg::axi_addr_t                   exp_ar [$];
  bridge_pkg::axi_resp_t                   exp_b [$];       // beats the link sent
  logic [`BR_RESP_W+`BR_DATA_W-1:0]        exp_r [$];       // resp, data
  int aw_cnt = 0;
  int w_cnt  = 0;
  int ar_cnt = 0;
  int b_cnt  = 0;

  kernel dut0 (
    .clk       (clk),
    .rstn      (rstn),
    .ocu_rstn  (ocu_rstn),
    .host_en   (host_en),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // expected staging contents after a pop, from the staging layout
  function automatic bridge_pkg::stage_t popped_stage(input bit is_r,
                                                      input bridge_pkg::axi_resp_t resp,
                                                      input bridge_pkg::axi_data_t data);
    bridge_pkg::stage_t s;
    s = '0;
    if (is_r) begin
      s[127:0]   = data;
      s[129:128] = resp;
    end else begin
      s[1:0] = resp;
    end
    return s;
  endfunction

  function automatic bridge_pkg::stage_t staged_bits();
    bridge_pkg::stage_t s;
    for (int i = 0; i < 8; i++)
      s[i*32 +: 32] = stage_model[i];
    return s;
  endfunction

  // called 1 ns after a rising edge, returns 1 ns after the next one
  task automatic host_write(input bridge_pkg::host_addr_t addr,
                            input bridge_pkg::host_word_t data);
    host_en   = 1'b1;
    host_we   = 4'hf;
    host_addr = addr;
    host_din  = data;
    @(posedge clk);
    #1;
    host_en = 1'b0;
    host_we = 4'h0;
  endtask

  task automatic host_read(input bridge_pkg::host_addr_t addr,
                           output bridge_pkg::host_word_t data);
    host_en   = 1'b1;
    host_we   = 4'h0;
    host_addr = addr;
    @(posedge clk);
    #1;
    host_en = 1'b0;
    data    = host_dout; // registered at that edge
  endtask

  task automatic write_stage(input int idx, input bridge_pkg::host_word_t data);
    host_write(bridge_pkg::host_addr_t'(`BR_REG_STAGE0 + 4*idx), data);
    stage_model[idx] = data;
  endtask

  task automatic check_stage(input bridge_pkg::stage_t exp);
    bridge_pkg::host_word_t got;
    for (int i = 0; i < 8; i++) begin
      host_read(bridge_pkg::host_addr_t'(`BR_REG_STAGE0 + 4*i), got);
      check_value($sformatf("stage word %0d", i), got, exp[i*32 +: 32]);
    end
  endtask

  task automatic wait_status(input bridge_pkg::host_addr_t addr, input string what,
                             output bridge_pkg::host_word_t v);
    int n;
    n = 0;
    host_read(addr, v);
    while (v[0] !== 1'b1) begin
      if (n == TIMEOUT)
        abort_run({what, " never showed a waiting entry"});
      n++;
      host_read(addr, v);
    end
  endtask

  task automatic wait_ocu(input logic level, input string what);
    int n;
    n = 0;
    while (ocu_rstn !== level) begin
      if (n == TIMEOUT)
        abort_run({"ocu_rstn did not change after ", what});
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic wait_writes(input int count);
    int n;
    n = 0;
    while (aw_cnt < count || w_cnt < count || b_cnt < count) begin
      if (n == TIMEOUT)
        abort_run("write beats or responses did not complete on the link");
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  // link model with random ready, one B per AW/W pair and one R per AR
  initial begin : link_model
    logic        aw_fire;
    logic        w_fire;
    logic        ar_fire;
    logic        b_fire;
    logic        r_fire;
    logic [31:0] rnd;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] d3;
    int          b_sent;
    int          r_sent;
    b_sent = 0;
    r_sent = 0;
    forever begin
      @(negedge clk);
      aw_fire = awvalid && awready;
      w_fire  = wvalid && wready;
      ar_fire = arvalid && arready;
      b_fire  = bvalid && bready;
      r_fire  = rvalid && rready;
      if (aw_fire) aw_cnt++;
      if (w_fire) w_cnt++;
      if (ar_fire) ar_cnt++;
      if (b_fire) begin
        b_cnt++;
        exp_b.push_back(bresp);
      end
      if (r_fire)
        exp_r.push_back({rresp, rdata});
      rnd = $random(seed);
      d0  = $random(seed);
      d1  = $random(seed);
      d2  = $random(seed);
      d3  = $random(seed);
      @(posedge clk);
      #1;
      if (b_fire) bvalid = 1'b0;
      if (r_fire) rvalid = 1'b0;
      if (!bvalid && b_sent < aw_cnt && b_sent < w_cnt) begin
        bresp  = rnd[5:4];
        bvalid = 1'b1;
        b_sent++;
      end
      if (!rvalid && r_sent < ar_cnt) begin
        rdata  = {d3, d2, d1, d0};
        rresp  = rnd[7:6];
        rvalid = 1'b1;
        r_sent++;
      end
      awready = rnd[0];
      wready  = rnd[1];
      arready = rnd[2];
    end
  end

  // compare each outbound beat with what the host staged
  always @(negedge clk) begin
    logic [`BR_STRB_W+`BR_DATA_W-1:0] w_exp;
    if (rstn) begin
      if (awvalid && awready) begin
        if (exp_aw.size() == 0)
          abort_run("write address beat without an AW push");
        else
          check_value("awaddr", awaddr, exp_aw.pop_front());
      end
      if (wvalid && wready) begin
        if (exp_w.size() == 0) begin
          abort_run("write data beat without a W push");
        end else begin
          w_exp = exp_w.pop_front();
          check_value("wdata", wdata, w_exp[`BR_DATA_W-1:0]);
          check_value("wstrb", wstrb, w_exp[`BR_STRB_W+`BR_DATA_W-1:`BR_DATA_W]);
        end
      end
      if (arvalid && arready) begin
        if (exp_ar.size() == 0)
          abort_run("read address beat without an AR push");
        else
          check_value("araddr", araddr, exp_ar.pop_front());
      end
    end
  end

  initial begin : run_tests
    bridge_pkg::stage_t               s;
    bridge_pkg::host_word_t           v;
    bridge_pkg::axi_resp_t            b_beat;
    logic [`BR_RESP_W+`BR_DATA_W-1:0] r_beat;
    host_en   = 1'b0;
    host_we   = 4'h0;
    host_addr = '0;
    host_din  = '0;
    awready   = 1'b0;
    wready    = 1'b0;
    arready   = 1'b0;
    bresp     = '0;
    bvalid    = 1'b0;
    rdata     = '0;
    rresp     = '0;
    rvalid    = 1'b0;
    rstn      = 1'b1;
    #5;
    rstn = 1'b0; // falling edge starts the reset
    repeat (8) @(posedge clk);
    #1;
    check_value("ocu_rstn", ocu_rstn, 0);
    check_value("awvalid", awvalid, 0);
    check_value("wvalid", wvalid, 0);
    check_value("arvalid", arvalid, 0);
    rstn = 1'b1;
    wait_ocu(1'b1, "reset release");

    // staging words read back unchanged
    for (int i = 0; i < 8; i++)
      write_stage(i, $random(seed));
    check_stage(staged_bits());

    // three AW/W pairs in flight under back-pressure
    repeat (3) begin
      write_stage(0, $random(seed));
      write_stage(1, $random(seed));
      s = staged_bits();
      exp_aw.push_back(s[63:0]);
      host_write(`BR_REG_AW_PUSH, '0);
      for (int i = 0; i < 5; i++)
        write_stage(i, $random(seed));
      s = staged_bits();
      exp_w.push_back(s[143:0]);
      host_write(`BR_REG_W_PUSH, '0);
    end
    wait_writes(3);

    // read request and R pop
    write_stage(0, $random(seed));
    write_stage(1, $random(seed));
    s = staged_bits();
    exp_ar.push_back(s[63:0]);
    host_write(`BR_REG_AR_PUSH, '0);
    wait_status(`BR_REG_R_STAT, "r_stat", v);
    check_value("r_stat", v, 1);
    if (exp_r.size() == 0)
      abort_run("R status set with no read data sent by the link");
    else
      r_beat = exp_r.pop_front();
    host_write(`BR_REG_R_POP, '0);
    check_stage(popped_stage(1'b1, r_beat[`BR_RESP_W+`BR_DATA_W-1:`BR_DATA_W],
                             r_beat[`BR_DATA_W-1:0]));
    host_read(`BR_REG_R_STAT, v);
    check_value("r_stat after pop", v, 0);

    // one B pop per write, oldest first
    repeat (3) begin
      wait_status(`BR_REG_B_STAT, "b_stat", v);
      check_value("b_stat", v, 1);
      if (exp_b.size() == 0)
        abort_run("B status set with no response sent by the link");
      else
        b_beat = exp_b.pop_front();
      host_write(`BR_REG_B_POP, '0);
      check_stage(popped_stage(1'b0, b_beat, '0));
    end
    host_read(`BR_REG_B_STAT, v);
    check_value("b_stat after pops", v, 0);

    // pops on empty queues leave staging alone
    for (int i = 0; i < 8; i++)
      write_stage(i, $random(seed));
    host_write(`BR_REG_B_POP, '0);
    host_write(`BR_REG_R_POP, '0);
    check_stage(staged_bits());

    // link reset switch
    host_write(`BR_REG_OCU_ASSERT, '0);
    wait_ocu(1'b0, "an assert write");
    host_write(`BR_REG_OCU_RELEASE, '0);
    wait_ocu(1'b1, "a release write");

    if (exp_aw.size() != 0 || exp_w.size() != 0 || exp_ar.size() != 0) begin
      abort_run("pushed requests never reached the link");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/kernel_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_asserts (
  input wire                         clk,
  input wire                         rstn,
  input wire                         ocu_rstn,
  input wire                         aw_push,
  input wire                         w_push,
  input wire                         ar_push,
  input wire                         aw_ready,
  input wire                         w_ready,
  input wire                         ar_ready,
  input wire bridge_pkg::axi_addr_t  awaddr,
  input wire                         awvalid,
  input wire                         awready,
  input wire bridge_pkg::axi_data_t  wdata,
  input wire bridge_pkg::axi_strb_t  wstrb,
  input wire                         wvalid,
  input wire                         wready,
  input wire bridge_pkg::axi_addr_t  araddr,
  input wire                         arvalid,
  input wire                         arready
);

  // a push into a full queue is dropped
  a_aw_push: assert property (@(posedge clk) disable iff (!rstn) aw_push |-> aw_ready)
    else $error("aw push while the queue is full");
  a_w_push: assert property (@(posedge clk) disable iff (!rstn) w_push |-> w_ready)
    else $error("w push while the queue is full");
  a_ar_push: assert property (@(posedge clk) disable iff (!rstn) ar_push |-> ar_ready)
    else $error("ar push while the queue is full");

  a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
      awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("awvalid or awaddr changed before awready");
  a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("wvalid or write data changed before wready");
  a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("arvalid or araddr changed before arready");

  a_ocu_in_reset: assert property (@(posedge clk) !rstn |-> !ocu_rstn)
    else $error("ocu_rstn high during reset");

endmodule

// sits between the register block and the channel port
bind kernel kernel_asserts asserts0 (
  .clk      (clk),
  .rstn     (rstn),
  .ocu_rstn (ocu_rstn),
  .aw_push  (aw_push),
  .w_push   (w_push),
  .ar_push  (ar_push),
  .aw_ready (aw_ready),
  .w_ready  (w_ready),
  .ar_ready (ar_ready),
  .awaddr   (awaddr),
  .awvalid  (awvalid),
  .awready  (awready),
  .wdata    (wdata),
  .wstrb    (wstrb),
  .wvalid   (wvalid),
  .wready   (wready),
  .araddr   (araddr),
  .arvalid  (arvalid),
  .arready  (arready)
);

`default_nettype wire

// ==== verilog/kernel.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel (
  input  wire                          clk,
  input  wire                          rstn,
  output logic                         ocu_rstn,

  // host register port
  input  wire                          host_en,
  input  wire  [3:0]                   host_we,
  input  wire  bridge_pkg::host_addr_t host_addr,
  input  wire  bridge_pkg::host_word_t host_din,
  output bridge_pkg::host_word_t       host_dout,

  // AXI4-Lite master toward the link
  output bridge_pkg::axi_addr_t        awaddr,
  output logic                         awvalid,
  input  wire                          awready,
  output bridge_pkg::axi_data_t        wdata,
  output bridge_pkg::axi_strb_t        wstrb,
  output logic                         wvalid,
  input  wire                          wready,
  input  wire  bridge_pkg::axi_resp_t  bresp,
  input  wire                          bvalid,
  output logic                         bready,
  output bridge_pkg::axi_addr_t        araddr,
  output logic                         arvalid,
  input  wire                          arready,
  input  wire  bridge_pkg::axi_data_t  rdata,
  input  wire  bridge_pkg::axi_resp_t  rresp,
  input  wire                          rvalid,
  output logic                         rready
);

  bridge_pkg::stage_t    stage;
  logic                  aw_push;
  logic                  w_push;
  logic                  ar_push;
  logic                  aw_ready;
  logic                  w_ready;
  logic                  ar_ready;
  logic                  b_avail;
  logic                  b_pop;
  bridge_pkg::axi_resp_t b_resp;
  logic                  r_avail;
  logic                  r_pop;
  bridge_pkg::axi_resp_t r_resp;
  bridge_pkg::axi_data_t r_data;

  host_regs regs0 (
    .clk       (clk),
    .rstn      (rstn),
    .host_en   (host_en),
    .host_we   (host_we),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout),
    .stage     (stage),
    .aw_push   (aw_push),
    .w_push    (w_push),
    .ar_push   (ar_push),
    .aw_ready  (aw_ready),
    .w_ready   (w_ready),
    .ar_ready  (ar_ready),
    .b_avail   (b_avail),
    .b_resp    (b_resp),
    .b_pop     (b_pop),
    .r_avail   (r_avail),
    .r_resp    (r_resp),
    .r_data    (r_data),
    .r_pop     (r_pop),
    .ocu_rstn  (ocu_rstn)
  );

  axi_master_port port0 (
    .clk      (clk),
    .rstn     (rstn),
    .stage    (stage),
    .aw_push  (aw_push),
    .w_push   (w_push),
    .ar_push  (ar_push),
    .aw_ready (aw_ready),
    .w_ready  (w_ready),
    .ar_ready (ar_ready),
    .b_pop    (b_pop),
    .b_avail  (b_avail),
    .b_resp   (b_resp),
    .r_pop    (r_pop),
    .r_avail  (r_avail),
    .r_resp   (r_resp),
    .r_data   (r_data),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready)
  );

endmodule

`default_nettype wire

// ==== verilog/axi_master_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module axi_master_port (
  input  wire                          clk,
  input  wire                          rstn,

  // register block side
  input  wire  bridge_pkg::stage_t     stage,
  input  wire                          aw_push,
  input  wire                          w_push,
  input  wire                          ar_push,
  output logic                         aw_ready,
  output logic                         w_ready,
  output logic                         ar_ready,
  input  wire                          b_pop,
  output logic                         b_avail,
  output bridge_pkg::axi_resp_t        b_resp,
  input  wire                          r_pop,
  output logic                         r_avail,
  output bridge_pkg::axi_resp_t        r_resp,
  output bridge_pkg::axi_data_t        r_data,

  // AXI4-Lite master
  output bridge_pkg::axi_addr_t        awaddr,
  output logic                         awvalid,
  input  wire                          awready,
  output bridge_pkg::axi_data_t        wdata,
  output bridge_pkg::axi_strb_t        wstrb,
  output logic                         wvalid,
  input  wire                          wready,
  input  wire  bridge_pkg::axi_resp_t  bresp,
  input  wire                          bvalid,
  output logic                         bready,
  output bridge_pkg::axi_addr_t        araddr,
  output logic                         arvalid,
  input  wire                          arready,
  input  wire  bridge_pkg::axi_data_t  rdata,
  input  wire  bridge_pkg::axi_resp_t  rresp,
  input  wire                          rvalid,
  output logic                         rready
);

  localparam int W_FIFO_W = `BR_STRB_W + `BR_DATA_W; // strb, data
  localparam int R_FIFO_W = `BR_RESP_W + `BR_DATA_W; // resp, data

  logic [W_FIFO_W-1:0] w_fifo_dout;
  logic [R_FIFO_W-1:0] r_fifo_dout;

  assign {wstrb, wdata}   = w_fifo_dout;
  assign {r_resp, r_data} = r_fifo_dout;

  fifo_bp #(.DATA_WIDTH(`BR_ADDR_W), .LOG2_DEPTH(`BR_FIFO_LOG2_DEPTH)) aw_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (aw_push),
    .wdata  (stage[`BR_ADDR_W-1:0]), // address in low word pair
    .wready (aw_ready),
    .rvalid (awvalid),
    .rdata  (awaddr),
    .rready (awready)
  );

  fifo_bp #(.DATA_WIDTH(W_FIFO_W), .LOG2_DEPTH(`BR_FIFO_LOG2_DEPTH)) w_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (w_push),
    .wdata  (stage[W_FIFO_W-1:0]),
    .wready (w_ready),
    .rvalid (wvalid),
    .rdata  (w_fifo_dout),
    .rready (wready)
  );

  fifo_bp #(.DATA_WIDTH(`BR_ADDR_W), .LOG2_DEPTH(`BR_FIFO_LOG2_DEPTH)) ar_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (ar_push),
    .wdata  (stage[`BR_ADDR_W-1:0]),
    .wready (ar_ready),
    .rvalid (arvalid),
    .rdata  (araddr),
    .rready (arready)
  );

  // bready and rready are the inbound not-full flags
  fifo_bp #(.DATA_WIDTH(`BR_RESP_W), .LOG2_DEPTH(`BR_FIFO_LOG2_DEPTH)) b_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (bvalid),
    .wdata  (bresp),
    .wready (bready),
    .rvalid (b_avail),
    .rdata  (b_resp),
    .rready (b_pop)
  );

  fifo_bp #(.DATA_WIDTH(R_FIFO_W), .LOG2_DEPTH(`BR_FIFO_LOG2_DEPTH)) r_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (rvalid),
    .wdata  ({rresp, rdata}),
    .wready (rready),
    .rvalid (r_avail),
    .rdata  (r_fifo_dout),
    .rready (r_pop)
  );

endmodule

`default_nettype wire

// ==== verilog/host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module host_regs (
  input  wire                           clk,
  input  wire                           rstn,

  // memory-style host port
  input  wire                           host_en,
  input  wire  [`BR_HOST_DATA_W/8-1:0]  host_we,
  input  wire  bridge_pkg::host_addr_t  host_addr,
  input  wire  bridge_pkg::host_word_t  host_din,
  output bridge_pkg::host_word_t        host_dout,

  output bridge_pkg::stage_t            stage,

  // outbound queue pushes
  output logic                          aw_push,
  output logic                          w_push,
  output logic                          ar_push,
  input  wire                           aw_ready,
  input  wire                           w_ready,
  input  wire                           ar_ready,

  // inbound queue heads and pops
  input  wire                           b_avail,
  input  wire  bridge_pkg::axi_resp_t   b_resp,
  output logic                          b_pop,
  input  wire                           r_avail,
  input  wire  bridge_pkg::axi_resp_t   r_resp,
  input  wire  bridge_pkg::axi_data_t   r_data,
  output logic                          r_pop,

  output logic                          ocu_rstn
);

  localparam int IDX_W = $clog2(`BR_STAGE_WORDS);

  logic                   wr_en;
  logic                   rd_en;
  bridge_pkg::host_addr_t stage_off;
  logic                   stage_hit;
  logic [IDX_W-1:0]       stage_idx;
  logic                   b_can_pop;
  logic                   r_can_pop;
  bridge_pkg::host_word_t b_stat;
  bridge_pkg::host_word_t r_stat;
  logic                   ocu_rstn_sw;

  assign wr_en = host_en && (host_we != '0);
  assign rd_en = host_en && (host_we == '0);

  // staging window, word aligned
  assign stage_off = host_addr - `BR_REG_STAGE0;
  assign stage_hit = (stage_off < bridge_pkg::host_addr_t'(`BR_STAGE_WORDS * 4)) &&
                     (stage_off[1:0] == 2'b00);
  assign stage_idx = stage_off[IDX_W+1:2];

  // head already being popped counts as gone
  assign b_can_pop = b_avail && !b_pop;
  assign r_can_pop = r_avail && !r_pop;

  // bit 0 entry waiting, bits 8 and up set while an outbound queue is full
  assign b_stat = bridge_pkg::host_word_t'({~w_ready, ~aw_ready, 7'b0, b_can_pop});
  assign r_stat = bridge_pkg::host_word_t'({~ar_ready, 7'b0, r_can_pop});

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push     <= 1'b0;
      w_push      <= 1'b0;
      ar_push     <= 1'b0;
      b_pop       <= 1'b0;
      r_pop       <= 1'b0;
      ocu_rstn_sw <= 1'b1;
      ocu_rstn    <= 1'b0;
    end else begin
      aw_push  <= wr_en && (host_addr == `BR_REG_AW_PUSH);
      w_push   <= wr_en && (host_addr == `BR_REG_W_PUSH);
      ar_push  <= wr_en && (host_addr == `BR_REG_AR_PUSH);
      b_pop    <= wr_en && (host_addr == `BR_REG_B_POP) && b_can_pop;
      r_pop    <= wr_en && (host_addr == `BR_REG_R_POP) && r_can_pop;
      ocu_rstn <= ocu_rstn_sw; // second stage of the link reset switch
      if (wr_en && (host_addr == `BR_REG_OCU_ASSERT))
        ocu_rstn_sw <= 1'b0;
      else if (wr_en && (host_addr == `BR_REG_OCU_RELEASE))
        ocu_rstn_sw <= 1'b1;
    end
  end

  // staging register and read data
  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (stage_hit) begin
        for (int b = 0; b < `BR_HOST_DATA_W/8; b++) begin
          if (host_we[b])
            stage[stage_idx*`BR_HOST_DATA_W + b*8 +: 8] <= host_din[b*8 +: 8];
        end
      end else if ((host_addr == `BR_REG_B_POP) && b_can_pop) begin
        stage <= bridge_pkg::stage_t'(b_resp);
      end else if ((host_addr == `BR_REG_R_POP) && r_can_pop) begin
        stage <= bridge_pkg::stage_t'({r_resp, r_data});
      end
    end

    if (rd_en) begin
      if (stage_hit)
        host_dout <= stage[stage_idx*`BR_HOST_DATA_W +: `BR_HOST_DATA_W];
      else if (host_addr == `BR_REG_B_STAT)
        host_dout <= b_stat;
      else if (host_addr == `BR_REG_R_STAT)
        host_dout <= r_stat;
      // other addresses keep the last value
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fifo_bp.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_bp #(
  parameter int DATA_WIDTH = 32,
  parameter int LOG2_DEPTH = 4
) (
  input  wire                   clk,
  input  wire                   rstn,
  input  wire                   wvalid,
  input  wire  [DATA_WIDTH-1:0] wdata,
  output logic                  wready,
  output logic                  rvalid,
  output logic [DATA_WIDTH-1:0] rdata,
  input  wire                   rready
);

  localparam int DEPTH = 1 << LOG2_DEPTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [LOG2_DEPTH-1:0] wptr;
  logic [LOG2_DEPTH-1:0] rptr;
  logic [LOG2_DEPTH:0]   count; // entries in mem, not counting the output register
  logic                  do_write;
  logic                  do_load;

  assign wready   = (count != (LOG2_DEPTH+1)'(DEPTH));
  assign do_write = wvalid && wready;
  // refill the output stage when it is empty or being taken
  assign do_load  = (count != '0) && (!rvalid || rready);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wptr   <= '0;
      rptr   <= '0;
      count  <= '0;
      rvalid <= 1'b0;
    end else begin
      if (do_write)
        wptr <= wptr + 1'b1;
      if (do_load)
        rptr <= rptr + 1'b1;
      count <= count + (LOG2_DEPTH+1)'(do_write) - (LOG2_DEPTH+1)'(do_load);
      if (do_load)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write)
      mem[wptr] <= wdata;
    if (do_load)
      rdata <= mem[rptr]; // head only moves on a load
  end

endmodule

`default_nettype wire

// ==== verilog/bridge_pkg.sv ====
`default_nettype none

`include "bridge_defs.svh"

package bridge_pkg;

  // AXI4-Lite link fields
  typedef logic [`BR_ADDR_W-1:0] axi_addr_t;
  typedef logic [`BR_DATA_W-1:0] axi_data_t;
  typedef logic [`BR_STRB_W-1:0] axi_strb_t;
  typedef logic [`BR_RESP_W-1:0] axi_resp_t;

  // host port
  typedef logic [`BR_HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [`BR_HOST_DATA_W-1:0] host_word_t;

  // 256-bit staging register shared by all queues
  typedef logic [`BR_STAGE_WORDS*`BR_HOST_DATA_W-1:0] stage_t;

endpackage

`default_nettype wire

// ==== verilog/bridge_defs.svh ====
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// AXI4-Lite link widths
`define BR_ADDR_W          64
`define BR_DATA_W          128
`define BR_STRB_W          16
`define BR_RESP_W          2

// host register port
`define BR_HOST_ADDR_W     15
`define BR_HOST_DATA_W     32
`define BR_STAGE_WORDS     8

// every queue holds 2**N entries
`define BR_FIFO_LOG2_DEPTH 4

// host register offsets, byte addressed
`define BR_REG_STAGE0      15'h000 // words 0..7 at 4-byte steps
`define BR_REG_AW_PUSH     15'h020
`define BR_REG_W_PUSH      15'h030
`define BR_REG_AR_PUSH     15'h040
`define BR_REG_B_STAT      15'h050
`define BR_REG_B_POP       15'h054
`define BR_REG_R_STAT      15'h060
`define BR_REG_R_POP       15'h064
`define BR_REG_OCU_ASSERT  15'h0c0
`define BR_REG_OCU_RELEASE 15'h0c4

`endif
